// File: test/pipe16_input.hex
// program from 00 and initial data memory from 40, one hex word per entry
// expected stores from 80 as address then data per line, an ffff address ends the list
@00
1045 // adi r1 = r0 + 5
1283 // adi r2 = r1 + 3, r1 from EX/MEM
0298 // add r3 = r1 + r2, r1 from MEM/WB
2660 // nand r4 = r3 nand r1
3BAB // lhi r5 = 1ab << 7
1B81 // adi r6 = r5 + 1
5620 // sw r3 to 20
5821 // sw r4 to 21
5C22 // sw r6 to 22
0C78 // add r7 = r6 + r1
5E23 // sw r7 to 23, data from EX/MEM
4201 // lw r1 from 1
0298 // add r3 = r1 + r2, load-use stall
5624 // sw r3 to 24
4802 // lw r4 from 2
5825 // sw r4 to 25, load-use stall on the data
8283 // beq r1 r2 not taken
5226 // sw r1 to 26
5427 // sw r2 to 27
1540 // adi r5 = r2 + 0
8A83 // beq r5 r2 taken to 23
5628 // skipped
5829 // skipped
5A2A // sw r5 to 2a
4C20 // lw r6 from 20
5C2B // sw r6 to 2b
8000 // halt
@40
1234
00F0
BEEF
0011
@80
0020 000D
0021 FFFA
0022 D581
0023 D586
0024 00F8
0025 BEEF
0026 00F0
0027 0008
002A 0008
002B 000D
FFFF

// File: pipe16.f
rtl/pipe16_pkg.sv
rtl/pipe16_if.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/pipe16_top.sv
test/pipe16_tb.sv

// File: Makefile
# pipe16 simulation with Verilator

.PHONY: all lint clean

all:
	verilator --binary --assert -f pipe16.f --top-module pipe16_tb
	@out=$$(./obj_dir/Vpipe16_tb); echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only -Wall --timing -f pipe16.f --top-module pipe16_tb

clean:
	rm -rf obj_dir

// File: test/pipe16_tb.sv
`timescale 1ns/1ps

module pipe16_tb import pipe16_pkg::*; ();

	// image layout in the input file
	localparam int IMAGE_SIZE = 256;
	localparam int MEM_WORDS  = 64;
	localparam int DATA_BASE  = 'h40;
	localparam int EXP_BASE   = 'h80;
	localparam int RST_CYCLES = 8;
	// beq r0 r0 0 spins on itself and marks the end of the program
	localparam logic [WORD_W-1:0] HALT_WORD = {OP_BEQ, 12'h000};

	logic              clk;
	logic              rst_n;
	logic [WORD_W-1:0] imem_addr;
	logic [WORD_W-1:0] imem_data;
	logic [WORD_W-1:0] dmem_addr;
	logic [WORD_W-1:0] dmem_wdata;
	logic              dmem_we;
	logic [WORD_W-1:0] dmem_rdata;

	logic [WORD_W-1:0] image [IMAGE_SIZE];
	logic [WORD_W-1:0] dmem [MEM_WORDS];

	int                errors;
	int                checks;
	int                cycles;
	int                cycle_limit;
	int                prog_words;
	int                exp_count;
	int                store_idx;
	int                halt_visits;
	logic              halted;
	logic [WORD_W-1:0] halt_addr;
	logic [WORD_W-1:0] prev_addr;

	pipe16_top i_pipe16_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [WORD_W-1:0] image_at(input int idx);
		return image[idx[7:0]];
	endfunction

	// instruction memory is the low 64 words of the image
	assign imem_data  = image[{2'b00, imem_addr[5:0]}];
	// data memory reads combinationally, aliased on 64 words
	assign dmem_rdata = dmem[dmem_addr[5:0]];

	// preload from the image while in reset, then take stores
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				dmem[i[5:0]] <= image_at(DATA_BASE + i);
			end
		end else if (dmem_we) begin
			dmem[dmem_addr[5:0]] <= dmem_wdata;
		end
	end

	task automatic load_image();
		for (int i = 0; i < IMAGE_SIZE; i++) begin
			// nop opcode with the address in the low byte
			image[i[7:0]] = {4'h7, 4'h0, i[7:0]};
		end
		$readmemh("test/pipe16_input.hex", image);
		// program length is up to and including the halt branch
		prog_words = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			if (prog_words == 0 && image_at(i) == HALT_WORD) begin
				prog_words = i + 1;
			end
		end
		if (prog_words == 0) begin
			$display("no halt branch found in the program image");
			errors++;
			prog_words = MEM_WORDS;
		end
		halt_addr = WORD_W'(prog_words - 1);
		// expected pairs run until an ffff address
		exp_count = 0;
		while (EXP_BASE + 2 * exp_count < IMAGE_SIZE
			&& image_at(EXP_BASE + 2 * exp_count) != 16'hFFFF) begin
			exp_count++;
		end
		cycle_limit = RST_CYCLES + 6 * prog_words + 20;
	endtask

	// compare one store on the data port with the next expected pair
	task automatic check_store();
		logic [WORD_W-1:0] exp_addr;
		logic [WORD_W-1:0] exp_data;
		if (dmem_we === 1'b1) begin
			exp_addr = image_at(EXP_BASE + 2 * store_idx);
			exp_data = image_at(EXP_BASE + 2 * store_idx + 1);
			if (store_idx >= exp_count) begin
				$display("unexpected store of %h to address %h at %t after the list ran out",
					dmem_wdata, dmem_addr, $time);
				errors++;
			end else begin
				checks++;
				if (dmem_addr !== exp_addr || dmem_wdata !== exp_data) begin
					$display("Fail %t: store %0d wrote %h to %h, expected %h to %h",
						$time, store_idx, dmem_wdata, dmem_addr, exp_data, exp_addr);
					errors++;
				end
			end
			store_idx++;
		end
	endtask

	// second arrival at the halt address means the halt branch was taken
	task automatic track_halt();
		if (imem_addr == halt_addr && prev_addr != halt_addr) begin
			halt_visits++;
		end
		if (halt_visits == 2) begin
			halted = 1'b1;
		end
		prev_addr = imem_addr;
	endtask

	initial begin
		rst_n       = 1'b0;
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		store_idx   = 0;
		halt_visits = 0;
		halted      = 1'b0;
		prev_addr   = '1;
		$timeformat(-9, 0, " ns", 0);
		load_image();

		// data port stays quiet through reset
		repeat (RST_CYCLES - 1) begin
			@(negedge clk);
			cycles++;
			checks++;
			if (dmem_we !== 1'b0) begin
				$display("Fail %t: dmem_we is %b during reset", $time, dmem_we);
				errors++;
			end
		end
		// the release edge is the last of the reset edges
		@(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		cycles++;
		checks++;
		if (imem_addr !== 16'h0000 || dmem_we !== 1'b0) begin
			$display("Fail %t: first fetch at %h with dmem_we %b, expected 0000 and 0",
				$time, imem_addr, dmem_we);
			errors++;
		end

		while (!halted && cycles < cycle_limit) begin
			check_store();
			track_halt();
			@(negedge clk);
			cycles++;
		end

		if (!halted) begin
			$display("timeout: the halt branch was not reached within %0d cycles", cycle_limit);
			errors++;
		end
		if (store_idx < exp_count) begin
			$display("only %0d of %0d expected stores were seen", store_idx, exp_count);
			errors++;
		end
		$display("checks %0d, stores %0d of %0d, cycles %0d, errors %0d",
			checks, store_idx, exp_count, cycles, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: rtl/pipe16_top.sv
`timescale 1ns/1ps

module pipe16_top import pipe16_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	output logic [WORD_W-1:0] imem_addr,
	input  logic [WORD_W-1:0] imem_data,
	output logic [WORD_W-1:0] dmem_addr,
	output logic [WORD_W-1:0] dmem_wdata,
	output logic              dmem_we,
	input  logic [WORD_W-1:0] dmem_rdata
);

	// IF/ID
	logic [WORD_W-1:0] ifid_pc;
	instr_u            ifid_instr;
	// decode sources for the load-use check
	logic [REG_AW-1:0] id_rs1;
	logic [REG_AW-1:0] id_rs2;
	// hazard and redirect
	logic              stall;
	logic [1:0]        fwd_a;
	logic [1:0]        fwd_b;
	logic              branch_taken;
	logic [WORD_W-1:0] branch_target;
	// writeback bus
	logic              wb_we;
	logic [REG_AW-1:0] wb_rd;
	logic [WORD_W-1:0] wb_data;

	id_ex_if  i_id_ex ();
	ex_mem_if i_ex_mem ();

	fetch_stage i_fetch_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.imem_data     (imem_data),
		.imem_addr     (imem_addr),
		.ifid_pc       (ifid_pc),
		.ifid_instr    (ifid_instr)
	);

	decode_stage i_decode_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.stall        (stall),
		.branch_taken (branch_taken),
		.ifid_pc      (ifid_pc),
		.ifid_instr   (ifid_instr),
		.wb_we        (wb_we),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.id_rs1       (id_rs1),
		.id_rs2       (id_rs2),
		.ix           (i_id_ex.src)
	);

	hazard_unit i_hazard_unit (
		.clk    (clk),
		.rst_n  (rst_n),
		.id_rs1 (id_rs1),
		.id_rs2 (id_rs2),
		.ix     (i_id_ex.mon),
		.mx     (i_ex_mem.mon),
		.wb_we  (wb_we),
		.wb_rd  (wb_rd),
		.stall  (stall),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b)
	);

	execute_stage i_execute_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.ix            (i_id_ex.dst),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.wb_data       (wb_data),
		.mx            (i_ex_mem.src),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	memory_stage i_memory_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.mx         (i_ex_mem.dst),
		.dmem_rdata (dmem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.wb_we      (wb_we),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

endmodule

// File: rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import pipe16_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	ex_mem_if.dst             mx,
	input  logic [WORD_W-1:0] dmem_rdata,
	output logic [WORD_W-1:0] dmem_addr,
	output logic [WORD_W-1:0] dmem_wdata,
	output logic              dmem_we,
	output logic              wb_we,
	output logic [REG_AW-1:0] wb_rd,
	output logic [WORD_W-1:0] wb_data
);

	logic [WORD_W-1:0] mem_result;

	// data memory port
	// reads are combinational, the write lands on the next edge
	assign dmem_addr  = mx.result;
	assign dmem_wdata = mx.store_data;
	assign dmem_we    = mx.mem_wr;

	// loads return memory data, everything else the execute result
	assign mem_result = mx.mem_rd ? dmem_rdata : mx.result;

	// MEM/WB write enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_we <= 1'b0;
		end else begin
			wb_we <= mx.reg_we;
		end
	end

	// MEM/WB payload, also the late forwarding source
	always_ff @(posedge clk) begin
		wb_rd   <= mx.rd;
		wb_data <= mem_result;
	end

	// decode never sets both for one instruction
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(mx.mem_rd && mx.mem_wr))
		else $error("load and store flagged together in EX/MEM");

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import pipe16_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	id_ex_if.dst              ix,
	input  logic [1:0]        fwd_a,
	input  logic [1:0]        fwd_b,
	input  logic [WORD_W-1:0] wb_data,
	ex_mem_if.src             mx,
	output logic              branch_taken,
	output logic [WORD_W-1:0] branch_target
);

	logic [WORD_W-1:0] op_a;
	logic [WORD_W-1:0] op_b;
	logic [WORD_W-1:0] alu_b;
	logic [WORD_W-1:0] alu_out;
	logic [WORD_W-1:0] imm6_zx;
	logic [WORD_W-1:0] imm6_sx;
	logic [WORD_W-1:0] lhi_data;
	logic [WORD_W-1:0] ex_result;

	function automatic logic [WORD_W-1:0] fwd_mux(
		input logic [1:0]        sel,
		input logic [WORD_W-1:0] reg_val,
		input logic [WORD_W-1:0] exm_val,
		input logic [WORD_W-1:0] wb_val
	);
		case (sel)
			FWD_EXMEM: return exm_val;
			FWD_WB:    return wb_val;
			default:   return reg_val;
		endcase
	endfunction

	// operands after bypass
	// EX/MEM result is read back from our own output register
	assign op_a = fwd_mux(fwd_a, ix.rs1_data, mx.result, wb_data);
	assign op_b = fwd_mux(fwd_b, ix.rs2_data, mx.result, wb_data);

	// alu immediate is zero extended, branch offset sign extended
	assign imm6_zx = {{(WORD_W-IMM6_W){1'b0}}, ix.instr.i_fmt.imm6};
	assign imm6_sx = {{(WORD_W-IMM6_W){ix.instr.i_fmt.imm6[IMM6_W-1]}}, ix.instr.i_fmt.imm6};

	// adi, lw and sw take the immediate as second operand
	assign alu_b   = ix.alu_imm ? imm6_zx : op_b;
	assign alu_out = (ix.alu_op == ALU_NAND) ? ~(op_a & alu_b) : op_a + alu_b;

	// lhi puts imm9 in the top bits
	assign lhi_data  = {ix.instr.j_fmt.imm9, {(WORD_W-IMM9_W){1'b0}}};
	assign ex_result = ix.is_lhi ? lhi_data : alu_out;

	// beq compares the bypassed ra and rb
	assign branch_taken  = ix.is_branch && (op_a == op_b);
	assign branch_target = ix.pc + imm6_sx;

	// EX/MEM control half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mx.reg_we <= 1'b0;
			mx.mem_rd <= 1'b0;
			mx.mem_wr <= 1'b0;
		end else begin
			mx.reg_we <= ix.reg_we;
			mx.mem_rd <= ix.mem_rd;
			mx.mem_wr <= ix.mem_wr;
		end
	end

	// EX/MEM payload half
	// store data is the bypassed ra of sw
	always_ff @(posedge clk) begin
		mx.rd         <= ix.rd;
		mx.result     <= ex_result;
		mx.store_data <= op_b;
	end

	// decode must squash the slot behind a redirect
	a_taken_is_branch: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |-> ix.is_branch ##1 !ix.is_branch)
		else $error("taken branch without a branch, or not followed by a bubble");

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import pipe16_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [REG_AW-1:0] id_rs1,
	input  logic [REG_AW-1:0] id_rs2,
	id_ex_if.mon              ix,
	ex_mem_if.mon             mx,
	input  logic              wb_we,
	input  logic [REG_AW-1:0] wb_rd,
	output logic              stall,
	output logic [1:0]        fwd_a,
	output logic [1:0]        fwd_b
);

	// youngest producer wins
	// EX/MEM never carries load data since a dependent load is held back a cycle
	function automatic logic [1:0] pick_fwd(
		input logic [REG_AW-1:0] src,
		input logic              exm_we,
		input logic [REG_AW-1:0] exm_rd,
		input logic              w_we,
		input logic [REG_AW-1:0] w_rd
	);
		if (exm_we && exm_rd == src) begin
			return FWD_EXMEM;
		end else if (w_we && w_rd == src) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	// load in execute feeding the instruction in decode
	// sources are compared whether used or not, a spare stall is harmless
	assign stall = ix.mem_rd && (ix.rd == id_rs1 || ix.rd == id_rs2);

	assign fwd_a = pick_fwd(ix.rs1_addr, mx.reg_we, mx.rd, wb_we, wb_rd);
	assign fwd_b = pick_fwd(ix.rs2_addr, mx.reg_we, mx.rd, wb_we, wb_rd);

	// the stall bubbles ID/EX, so the load is gone the next cycle
	a_single_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> !stall)
		else $error("load-use stall lasted more than one cycle");

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import pipe16_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  logic              branch_taken,
	input  logic [WORD_W-1:0] ifid_pc,
	input  instr_u            ifid_instr,
	input  logic              wb_we,
	input  logic [REG_AW-1:0] wb_rd,
	input  logic [WORD_W-1:0] wb_data,
	output logic [REG_AW-1:0] id_rs1,
	output logic [REG_AW-1:0] id_rs2,
	id_ex_if.src              ix
);

	logic [OP_W-1:0]   op;
	logic              bubble;
	logic              dec_reg_we;
	logic              dec_mem_rd;
	logic              dec_mem_wr;
	logic              dec_branch;
	logic              dec_alu_imm;
	logic              dec_alu_op;
	logic              dec_lhi;
	logic [REG_AW-1:0] dec_rd;
	logic [WORD_W-1:0] rs1_data;
	logic [WORD_W-1:0] rs2_data;

	assign op = ifid_instr.r_fmt.op;
	// load-use hold or branch flush both kill the entry
	assign bubble = stall | branch_taken;

	always_comb begin
		dec_reg_we  = 1'b0;
		dec_mem_rd  = 1'b0;
		dec_mem_wr  = 1'b0;
		dec_branch  = 1'b0;
		dec_alu_imm = 1'b0;
		dec_alu_op  = ALU_ADD;
		dec_lhi     = 1'b0;
		// lhi and lw write ra
		dec_rd      = ifid_instr.j_fmt.ra;
		id_rs1      = ifid_instr.r_fmt.ra;
		id_rs2      = ifid_instr.r_fmt.rb;
		case (op)
			OP_ADD, OP_NAND: begin
				dec_reg_we = 1'b1;
				dec_alu_op = (op == OP_NAND) ? ALU_NAND : ALU_ADD;
				dec_rd     = ifid_instr.r_fmt.rc;
			end
			OP_ADI: begin
				dec_reg_we  = 1'b1;
				dec_alu_imm = 1'b1;
				dec_rd      = ifid_instr.i_fmt.rb;
			end
			OP_LHI: begin
				dec_reg_we = 1'b1;
				dec_lhi    = 1'b1;
			end
			OP_LW: begin
				dec_reg_we  = 1'b1;
				dec_mem_rd  = 1'b1;
				dec_alu_imm = 1'b1;
				id_rs1      = ifid_instr.i_fmt.rb;
			end
			OP_SW: begin
				dec_mem_wr  = 1'b1;
				dec_alu_imm = 1'b1;
				// base in rb, store data comes from ra
				id_rs1      = ifid_instr.i_fmt.rb;
				id_rs2      = ifid_instr.i_fmt.ra;
			end
			OP_BEQ: begin
				dec_branch = 1'b1;
			end
			// unknown opcodes fall through with no side effects
			default: ;
		endcase
	end

	reg_file i_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (id_rs1),
		.rd_addr_b (id_rs2),
		.wr_en     (wb_we),
		.wr_addr   (wb_rd),
		.wr_data   (wb_data),
		.rd_data_a (rs1_data),
		.rd_data_b (rs2_data)
	);

	// ID/EX control half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ix.reg_we    <= 1'b0;
			ix.mem_rd    <= 1'b0;
			ix.mem_wr    <= 1'b0;
			ix.is_branch <= 1'b0;
		end else if (bubble) begin
			ix.reg_we    <= 1'b0;
			ix.mem_rd    <= 1'b0;
			ix.mem_wr    <= 1'b0;
			ix.is_branch <= 1'b0;
		end else begin
			ix.reg_we    <= dec_reg_we;
			ix.mem_rd    <= dec_mem_rd;
			ix.mem_wr    <= dec_mem_wr;
			ix.is_branch <= dec_branch;
		end
	end

	// ID/EX payload half, harmless once the control bits are clear
	always_ff @(posedge clk) begin
		ix.pc       <= ifid_pc;
		ix.instr    <= ifid_instr;
		ix.rs1_data <= rs1_data;
		ix.rs2_data <= rs2_data;
		ix.rs1_addr <= id_rs1;
		ix.rs2_addr <= id_rs2;
		ix.rd       <= dec_rd;
		ix.alu_imm  <= dec_alu_imm;
		ix.alu_op   <= dec_alu_op;
		ix.is_lhi   <= dec_lhi;
	end

	// second slot behind a taken branch, emptied by the nop that fetch puts in IF/ID
	// must reach execute with no side effects either
	a_bubble_clean: assert property (@(posedge clk) disable iff (!rst_n)
		branch_taken |-> ##2 !(ix.reg_we || ix.mem_wr || ix.mem_rd))
		else $error("write enable survived a flush into ID/EX");

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import pipe16_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              stall,
	input  logic              branch_taken,
	input  logic [WORD_W-1:0] branch_target,
	input  logic [WORD_W-1:0] imem_data,
	output logic [WORD_W-1:0] imem_addr,
	output logic [WORD_W-1:0] ifid_pc,
	output instr_u            ifid_instr
);

	logic [WORD_W-1:0] pc;

	// instruction memory answers in the same cycle
	assign imem_addr = pc;

	// program counter
	// a taken branch overrides a stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

	// IF/ID word, empty after reset
	// the word in flight is dropped when execute redirects
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ifid_instr <= NOP_WORD;
		end else if (branch_taken) begin
			ifid_instr <= NOP_WORD;
		end else if (!stall) begin
			ifid_instr <= imem_data;
		end
	end

	// pc of the word in IF/ID, only used by beq
	always_ff @(posedge clk) begin
		if (!stall) begin
			ifid_pc <= pc;
		end
	end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import pipe16_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [REG_AW-1:0] rd_addr_a,
	input  logic [REG_AW-1:0] rd_addr_b,
	input  logic              wr_en,
	input  logic [REG_AW-1:0] wr_addr,
	input  logic [WORD_W-1:0] wr_data,
	output logic [WORD_W-1:0] rd_data_a,
	output logic [WORD_W-1:0] rd_data_b
);

	logic [WORD_W-1:0] regs [NUM_REGS];

	// r0..r7 all general purpose
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// writeback in the same cycle bypasses the array
	// so decode sees the value written at the end of this cycle
	assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

// File: rtl/pipe16_if.sv
`timescale 1ns/1ps

// ID/EX pipeline register contents
interface id_ex_if import pipe16_pkg::*; ();
	logic [WORD_W-1:0] pc;
	instr_u            instr;
	logic [WORD_W-1:0] rs1_data;
	logic [WORD_W-1:0] rs2_data;
	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [REG_AW-1:0] rd;
	// control bits, cleared by a bubble
	logic              reg_we;
	logic              mem_rd;
	logic              mem_wr;
	logic              is_branch;
	// operation select
	logic              alu_imm;
	logic              alu_op;
	logic              is_lhi;

	modport src (output pc, instr, rs1_data, rs2_data, rs1_addr, rs2_addr, rd,
		reg_we, mem_rd, mem_wr, is_branch, alu_imm, alu_op, is_lhi);
	modport dst (input pc, instr, rs1_data, rs2_data, rd,
		reg_we, mem_rd, mem_wr, is_branch, alu_imm, alu_op, is_lhi);
	// hazard unit only needs the register numbers and the load flag
	modport mon (input rs1_addr, rs2_addr, rd, mem_rd);
endinterface

// EX/MEM pipeline register contents
interface ex_mem_if import pipe16_pkg::*; ();
	logic              reg_we;
	logic              mem_rd;
	logic              mem_wr;
	logic [REG_AW-1:0] rd;
	// alu result, lhi value or memory address
	logic [WORD_W-1:0] result;
	logic [WORD_W-1:0] store_data;

	modport src (output reg_we, mem_rd, mem_wr, rd, result, store_data);
	modport dst (input reg_we, mem_rd, mem_wr, rd, result, store_data);
	modport mon (input reg_we, rd);
endinterface

// File: rtl/pipe16_pkg.sv
package pipe16_pkg;

	// datapath geometry
	localparam int WORD_W   = 16;
	localparam int REG_AW   = 3;
	localparam int NUM_REGS = 8;
	localparam int OP_W     = 4;
	localparam int IMM6_W   = 6;
	localparam int IMM9_W   = 9;

	// opcodes of the supported subset
	// anything not listed decodes to no control bits and runs as a nop
	localparam logic [OP_W-1:0] OP_ADD  = 4'b0000;
	localparam logic [OP_W-1:0] OP_ADI  = 4'b0001;
	localparam logic [OP_W-1:0] OP_NAND = 4'b0010;
	localparam logic [OP_W-1:0] OP_LHI  = 4'b0011;
	localparam logic [OP_W-1:0] OP_LW   = 4'b0100;
	localparam logic [OP_W-1:0] OP_SW   = 4'b0101;
	localparam logic [OP_W-1:0] OP_NOP  = 4'b0111;
	localparam logic [OP_W-1:0] OP_BEQ  = 4'b1000;

	// filler word pushed into IF/ID on a flush
	localparam logic [WORD_W-1:0] NOP_WORD = {OP_NOP, {(WORD_W-OP_W){1'b0}}};

	// operand source in execute
	localparam logic [1:0] FWD_NONE  = 2'd0;
	localparam logic [1:0] FWD_EXMEM = 2'd1;
	localparam logic [1:0] FWD_WB    = 2'd2;

	// alu function
	localparam logic ALU_ADD  = 1'b0;
	localparam logic ALU_NAND = 1'b1;

	// one instruction word, three field layouts
	typedef union packed {
		// register form, add and nand
		struct packed {
			logic [OP_W-1:0]   op;
			logic [REG_AW-1:0] ra;
			logic [REG_AW-1:0] rb;
			logic [REG_AW-1:0] rc;
			logic [2:0]        unused;
		} r_fmt;
		// immediate form, adi, lw, sw and beq
		struct packed {
			logic [OP_W-1:0]   op;
			logic [REG_AW-1:0] ra;
			logic [REG_AW-1:0] rb;
			logic [IMM6_W-1:0] imm6;
		} i_fmt;
		// long immediate form, lhi
		struct packed {
			logic [OP_W-1:0]   op;
			logic [REG_AW-1:0] ra;
			logic [IMM9_W-1:0] imm9;
		} j_fmt;
	} instr_u;

endpackage
